/* soc_fabric_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Fabric widths, master bank encodings and I/O register indices
//////////////////////////////////////////////////////////////////////

package soc_fabric_pkg;

  // Data paths
  localparam int DATA_W = 32;
  localparam int UART_W = 8;
  localparam int LED_W = 16;

  // Master address fields
  localparam int BASE_W = 11;
  localparam int W_BANK_W = 3;
  localparam int R_BANK_W = 2;
  localparam int W_ADDR_W = W_BANK_W + BASE_W;
  localparam int R_ADDR_W = R_BANK_W + BASE_W;
  localparam int IO_ADDR_W = 5;

  // Values 2 to 7 belong to the PEs, which match their own id
  typedef enum logic [W_BANK_W-1:0] {
    W_BANK_MEM_D  = 3'd0,
    W_BANK_IO_REG = 3'd1
  } w_bank_e;

  // Bank 2 is unmapped and reads zero
  typedef enum logic [R_BANK_W-1:0] {
    R_BANK_MEM_D  = 2'd0,
    R_BANK_IO_REG = 2'd1,
    R_BANK_S2M    = 2'd3
  } r_bank_e;

  typedef enum logic [IO_ADDR_W-1:0] {
    IO_W_RESET_PE = 5'd0,
    IO_W_LED      = 5'd1,
    IO_W_UART     = 5'd2
  } io_w_reg_e;

  typedef enum logic [IO_ADDR_W-1:0] {
    IO_R_UART_BUSY = 5'd0
  } io_r_reg_e;

endpackage

/* master_wr_if.sv */
//////////////////////////////////////////////////////////////////////
// Registered master write toward data memory and I/O registers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface master_wr_if;

  logic [soc_fabric_pkg::W_ADDR_W-1:0] addr;
  logic [soc_fabric_pkg::DATA_W-1:0]   data;
  // One enable per target, already bank decoded
  logic                                mem_we;
  logic                                io_we;

  modport source (
    output addr, data, mem_we, io_we
  );

  modport sink (
    input addr, data, mem_we, io_we
  );

endinterface

/* shared_ram.sv */
//////////////////////////////////////////////////////////////////////
// Simple dual-port RAM, registered read
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module shared_ram #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              we,
  input  logic [ADDR_W-1:0] w_addr,
  input  logic [DATA_W-1:0] w_data,
  input  logic [ADDR_W-1:0] r_addr,
  output logic [DATA_W-1:0] r_data
);

  logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

  // Read sees the old word on a same-address collision
  always_ff @(posedge clk)
  begin
    if (we)
      mem[w_addr] <= w_data;
    r_data <= mem[r_addr];
  end

endmodule

/* master_write_decode.sv */
//////////////////////////////////////////////////////////////////////
// Master write register stage, bank decode, PE broadcast
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module master_write_decode (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                m_w_valid,
  input  logic [soc_fabric_pkg::W_ADDR_W-1:0] m_w_addr,
  input  logic [soc_fabric_pkg::DATA_W-1:0]   m_w_data,
  master_wr_if.source                         wr,
  output logic                                pe_w_valid,
  output logic [soc_fabric_pkg::W_ADDR_W-1:0] pe_w_addr,
  output logic [soc_fabric_pkg::DATA_W-1:0]   pe_w_data
);

  localparam int W_ADDR_W = soc_fabric_pkg::W_ADDR_W;
  localparam int BASE_W = soc_fabric_pkg::BASE_W;

  soc_fabric_pkg::w_bank_e         bank;
  logic [W_ADDR_W-1:0]             addr_q;
  logic [soc_fabric_pkg::DATA_W-1:0] data_q;
  logic                            mem_we_q;
  logic                            io_we_q;
  logic                            pe_we_q;

  assign bank = soc_fabric_pkg::w_bank_e'(m_w_addr[W_ADDR_W-1:BASE_W]);

  always_ff @(posedge clk)
  begin
    addr_q <= m_w_addr;
    data_q <= m_w_data;
  end

  // Exactly one target per accepted write
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mem_we_q <= 1'b0;
      io_we_q <= 1'b0;
      pe_we_q <= 1'b0;
    end
    else
    begin
      mem_we_q <= m_w_valid && (bank == soc_fabric_pkg::W_BANK_MEM_D);
      io_we_q <= m_w_valid && (bank == soc_fabric_pkg::W_BANK_IO_REG);
      pe_we_q <= m_w_valid && (bank != soc_fabric_pkg::W_BANK_MEM_D)
                 && (bank != soc_fabric_pkg::W_BANK_IO_REG);
    end
  end

  assign wr.addr = addr_q;
  assign wr.data = data_q;
  assign wr.mem_we = mem_we_q;
  assign wr.io_we = io_we_q;

  // PEs see the full address and pick their own bank
  assign pe_w_valid = pe_we_q;
  assign pe_w_addr = addr_q;
  assign pe_w_data = data_q;

endmodule

/* io_reg_file.sv */
//////////////////////////////////////////////////////////////////////
// Control registers, UART busy status, UART byte handoff
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module io_reg_file (
  input  logic                                 clk,
  input  logic                                 rst_n,
  master_wr_if.sink                            wr,
  input  logic [soc_fabric_pkg::IO_ADDR_W-1:0] rd_index,
  input  logic                                 tx_ready,
  output logic [soc_fabric_pkg::DATA_W-1:0]    rd_data,
  output logic [soc_fabric_pkg::LED_W-1:0]     led,
  output logic                                 pe_soft_reset,
  output logic                                 tx_valid,
  output logic [soc_fabric_pkg::UART_W-1:0]    tx_data
);

  localparam int DATA_W = soc_fabric_pkg::DATA_W;
  localparam int IO_ADDR_W = soc_fabric_pkg::IO_ADDR_W;

  soc_fabric_pkg::io_w_reg_e w_index;
  soc_fabric_pkg::io_r_reg_e r_index;
  logic                      uart_load;

  assign w_index = soc_fabric_pkg::io_w_reg_e'(wr.addr[IO_ADDR_W-1:0]);
  assign uart_load = wr.io_we && (w_index == soc_fabric_pkg::IO_W_UART);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      led <= '0;
      pe_soft_reset <= 1'b0;
    end
    else if (wr.io_we)
    begin
      case (w_index)
        soc_fabric_pkg::IO_W_LED:
          led <= wr.data[soc_fabric_pkg::LED_W-1:0];
        soc_fabric_pkg::IO_W_RESET_PE:
          pe_soft_reset <= wr.data[0];
        default:
          ;
      endcase
    end
  end

  // A new byte overrides a pending one
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_valid <= 1'b0;
    else if (uart_load)
      tx_valid <= 1'b1;
    else if (tx_ready)
      tx_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (uart_load)
      tx_data <= wr.data[soc_fabric_pkg::UART_W-1:0];
  end

  assign r_index = soc_fabric_pkg::io_r_reg_e'(rd_index);

  // Busy while the byte waits for the UART
  always_comb
  begin
    case (r_index)
      soc_fabric_pkg::IO_R_UART_BUSY:
        rd_data = {{(DATA_W-1){1'b0}}, tx_valid};
      default:
        rd_data = '0;
    endcase
  end

endmodule

/* result_harvester.sv */
//////////////////////////////////////////////////////////////////////
// Round-robin PE result collection into the result memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module result_harvester #(
  parameter int CORES = 4,
  parameter int S2M_AW = 6
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [CORES-1:0]                          pe_valid,
  input  logic [CORES*S2M_AW-1:0]                   pe_res_addr,
  input  logic [CORES*soc_fabric_pkg::DATA_W-1:0]   pe_res_data,
  output logic [CORES-1:0]                          pe_ready,
  output logic                                      s2m_we,
  output logic [S2M_AW-1:0]                         s2m_w_addr,
  output logic [soc_fabric_pkg::DATA_W-1:0]         s2m_w_data
);

  localparam int DATA_W = soc_fabric_pkg::DATA_W;
  localparam int PTR_W = (CORES > 1) ? $clog2(CORES) : 1;

  logic [PTR_W-1:0]  lane;
  logic              take;
  logic [S2M_AW-1:0] lane_addr;
  logic [DATA_W-1:0] lane_data;

  // Slot pointer runs whether or not the lane has data
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      lane <= '0;
    else if (lane == PTR_W'(CORES - 1))
      lane <= '0;
    else
      lane <= lane + 1'b1;
  end

  always_comb
  begin
    pe_ready = '0;
    pe_ready[lane] = 1'b1;
  end

  assign take = pe_valid[lane];
  assign lane_addr = pe_res_addr[lane*S2M_AW +: S2M_AW];
  assign lane_data = pe_res_data[lane*DATA_W +: DATA_W];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      s2m_we <= 1'b0;
    else
      s2m_we <= take;
  end

  // Item lands in the result memory one edge after acceptance
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      s2m_w_addr <= lane_addr;
      s2m_w_data <= lane_data;
    end
  end

endmodule

/* master_read_mux.sv */
//////////////////////////////////////////////////////////////////////
// Master read bank pipeline and output data select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module master_read_mux (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 m_r_valid,
  input  logic [soc_fabric_pkg::R_ADDR_W-1:0]  m_r_addr,
  input  logic [soc_fabric_pkg::DATA_W-1:0]    mem_d_rdata,
  input  logic [soc_fabric_pkg::DATA_W-1:0]    s2m_rdata,
  input  logic [soc_fabric_pkg::DATA_W-1:0]    io_rdata,
  output logic [soc_fabric_pkg::IO_ADDR_W-1:0] io_rd_index,
  output logic [soc_fabric_pkg::DATA_W-1:0]    m_r_data,
  output logic                                 m_r_data_valid
);

  localparam int R_ADDR_W = soc_fabric_pkg::R_ADDR_W;
  localparam int BASE_W = soc_fabric_pkg::BASE_W;

  logic                      valid_q;
  soc_fabric_pkg::r_bank_e   bank_q;

  // First stage lines up with the RAM read register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
      bank_q <= soc_fabric_pkg::R_BANK_MEM_D;
      io_rd_index <= '0;
    end
    else
    begin
      valid_q <= m_r_valid;
      bank_q <= soc_fabric_pkg::r_bank_e'(m_r_addr[R_ADDR_W-1:BASE_W]);
      io_rd_index <= m_r_addr[soc_fabric_pkg::IO_ADDR_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      m_r_data_valid <= 1'b0;
    else
      m_r_data_valid <= valid_q;
  end

  always_ff @(posedge clk)
  begin
    case (bank_q)
      soc_fabric_pkg::R_BANK_MEM_D:
        m_r_data <= mem_d_rdata;
      soc_fabric_pkg::R_BANK_IO_REG:
        m_r_data <= io_rdata;
      soc_fabric_pkg::R_BANK_S2M:
        m_r_data <= s2m_rdata;
      default:
        m_r_data <= '0;
    endcase
  end

endmodule

/* soc_fabric.sv */
//////////////////////////////////////////////////////////////////////
// Host fabric top: write decode, read mux, I/O regs, harvester, RAMs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_fabric #(
  parameter int CORES = 4,
  parameter int MEM_D_AW = 8,
  parameter int S2M_AW = 6
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  // Master write
  input  logic                                    m_w_valid,
  input  logic [soc_fabric_pkg::W_ADDR_W-1:0]     m_w_addr,
  input  logic [soc_fabric_pkg::DATA_W-1:0]       m_w_data,
  // Master read
  input  logic                                    m_r_valid,
  input  logic [soc_fabric_pkg::R_ADDR_W-1:0]     m_r_addr,
  output logic [soc_fabric_pkg::DATA_W-1:0]       m_r_data,
  output logic                                    m_r_data_valid,
  // PE broadcast
  output logic                                    pe_w_valid,
  output logic [soc_fabric_pkg::W_ADDR_W-1:0]     pe_w_addr,
  output logic [soc_fabric_pkg::DATA_W-1:0]       pe_w_data,
  // PE results
  input  logic [CORES-1:0]                        pe_valid,
  output logic [CORES-1:0]                        pe_ready,
  input  logic [CORES*S2M_AW-1:0]                 pe_res_addr,
  input  logic [CORES*soc_fabric_pkg::DATA_W-1:0] pe_res_data,
  // Board side
  output logic [soc_fabric_pkg::LED_W-1:0]        led,
  output logic                                    pe_soft_reset,
  output logic                                    tx_valid,
  output logic [soc_fabric_pkg::UART_W-1:0]       tx_data,
  input  logic                                    tx_ready
);

  localparam int DATA_W = soc_fabric_pkg::DATA_W;

  master_wr_if wr_bus ();

  logic [DATA_W-1:0]                    mem_d_rdata;
  logic [DATA_W-1:0]                    s2m_rdata;
  logic [DATA_W-1:0]                    io_rdata;
  logic [soc_fabric_pkg::IO_ADDR_W-1:0] io_rd_index;
  logic                                 s2m_we;
  logic [S2M_AW-1:0]                    s2m_w_addr;
  logic [DATA_W-1:0]                    s2m_w_data;

  master_write_decode u_wr_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .m_w_valid  (m_w_valid),
    .m_w_addr   (m_w_addr),
    .m_w_data   (m_w_data),
    .wr         (wr_bus),
    .pe_w_valid (pe_w_valid),
    .pe_w_addr  (pe_w_addr),
    .pe_w_data  (pe_w_data)
  );

  shared_ram #(
    .DATA_W (DATA_W),
    .ADDR_W (MEM_D_AW)
  ) u_mem_d (
    .clk    (clk),
    .we     (wr_bus.mem_we),
    .w_addr (wr_bus.addr[MEM_D_AW-1:0]),
    .w_data (wr_bus.data),
    .r_addr (m_r_addr[MEM_D_AW-1:0]),
    .r_data (mem_d_rdata)
  );

  io_reg_file u_io_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr            (wr_bus),
    .rd_index      (io_rd_index),
    .tx_ready      (tx_ready),
    .rd_data       (io_rdata),
    .led           (led),
    .pe_soft_reset (pe_soft_reset),
    .tx_valid      (tx_valid),
    .tx_data       (tx_data)
  );

  result_harvester #(
    .CORES  (CORES),
    .S2M_AW (S2M_AW)
  ) u_harvester (
    .clk         (clk),
    .rst_n       (rst_n),
    .pe_valid    (pe_valid),
    .pe_res_addr (pe_res_addr),
    .pe_res_data (pe_res_data),
    .pe_ready    (pe_ready),
    .s2m_we      (s2m_we),
    .s2m_w_addr  (s2m_w_addr),
    .s2m_w_data  (s2m_w_data)
  );

  shared_ram #(
    .DATA_W (DATA_W),
    .ADDR_W (S2M_AW)
  ) u_s2m (
    .clk    (clk),
    .we     (s2m_we),
    .w_addr (s2m_w_addr),
    .w_data (s2m_w_data),
    .r_addr (m_r_addr[S2M_AW-1:0]),
    .r_data (s2m_rdata)
  );

  master_read_mux u_rd_mux (
    .clk            (clk),
    .rst_n          (rst_n),
    .m_r_valid      (m_r_valid),
    .m_r_addr       (m_r_addr),
    .mem_d_rdata    (mem_d_rdata),
    .s2m_rdata      (s2m_rdata),
    .io_rdata       (io_rdata),
    .io_rd_index    (io_rd_index),
    .m_r_data       (m_r_data),
    .m_r_data_valid (m_r_data_valid)
  );

endmodule

/* tb_soc_fabric.sv */
//////////////////////////////////////////////////////////////////////
// Directed testbench for the host fabric with clock, LFSR, tests and summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_soc_fabric;

  localparam int CORES = 4;
  localparam int S2M_AW = 6;
  localparam int DATA_W = soc_fabric_pkg::DATA_W;
  localparam int W_ADDR_W = soc_fabric_pkg::W_ADDR_W;
  localparam int R_ADDR_W = soc_fabric_pkg::R_ADDR_W;
  localparam int TIMEOUT_CYCLES = 2000;

  logic                     clk;
  logic                     rst_n;
  logic                     m_w_valid;
  logic [W_ADDR_W-1:0]      m_w_addr;
  logic [DATA_W-1:0]        m_w_data;
  logic                     m_r_valid;
  logic [R_ADDR_W-1:0]      m_r_addr;
  logic [DATA_W-1:0]        m_r_data;
  logic                     m_r_data_valid;
  logic                     pe_w_valid;
  logic [W_ADDR_W-1:0]      pe_w_addr;
  logic [DATA_W-1:0]        pe_w_data;
  logic [CORES-1:0]         pe_valid;
  logic [CORES-1:0]         pe_ready;
  logic [CORES*S2M_AW-1:0]  pe_res_addr;
  logic [CORES*DATA_W-1:0]  pe_res_data;
  logic [15:0]              led;
  logic                     pe_soft_reset;
  logic                     tx_valid;
  logic [7:0]               tx_data;
  logic                     tx_ready;

  logic [31:0]              lfsr_state;
  int                       cycles = 0;
  int                       errors = 0;
  int                       tests_run = 0;
  int                       tests_failed = 0;
  logic [R_ADDR_W-1:0]      burst_addr [0:15];
  logic [DATA_W-1:0]        burst_exp [0:15];

  soc_fabric #(
    .CORES    (CORES),
    .MEM_D_AW (8),
    .S2M_AW   (S2M_AW)
  ) DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hA300_0000 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [W_ADDR_W-1:0] wr_address(input logic [2:0] bank,
                                                     input logic [10:0] base);
    return {bank, base};
  endfunction

  function automatic logic [R_ADDR_W-1:0] rd_address(input logic [1:0] bank,
                                                     input logic [10:0] base);
    return {bank, base};
  endfunction

  // Distinct result memory slot per lane and item
  function automatic logic [S2M_AW-1:0] harvest_addr(input int lane, input int idx);
    return S2M_AW'(lane * 16 + idx * 5 + 2);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors)
      $display("%s: passed", name);
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - start_errors);
    end
  endtask

  // One write cycle that returns on the next falling edge
  task automatic issue_write(input logic [W_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    m_w_valid = 1'b1;
    m_w_addr = addr;
    m_w_data = data;
    @(negedge clk);
    m_w_valid = 1'b0;
  endtask

  // Back-to-back reads answered two cycles later
  task automatic run_read_burst(input int n, input string name);
    logic exp_valid;
    for (int k = 0; k <= n + 2; k++)
    begin
      @(negedge clk);
      exp_valid = (k >= 2) && (k - 2 < n);
      if (m_r_data_valid !== exp_valid)
        report_mismatch("m_r_data_valid", m_r_data_valid, exp_valid);
      if (exp_valid && m_r_data !== burst_exp[k - 2])
        report_mismatch(name, m_r_data, burst_exp[k - 2]);
      m_r_valid = (k < n);
      if (k < n)
        m_r_addr = burst_addr[k];
    end
  endtask

  task automatic reset_test();
    int start_errors;
    start_errors = errors;
    if (pe_w_valid !== 1'b0)
      report_mismatch("pe_w_valid", pe_w_valid, 0);
    if (m_r_data_valid !== 1'b0)
      report_mismatch("m_r_data_valid", m_r_data_valid, 0);
    if (tx_valid !== 1'b0)
      report_mismatch("tx_valid", tx_valid, 0);
    if (pe_soft_reset !== 1'b0)
      report_mismatch("pe_soft_reset", pe_soft_reset, 0);
    if (led !== 16'h0)
      report_mismatch("led", led, 0);
    if (pe_ready[CORES-1:1] !== '0)
      report_mismatch("pe_ready[3:1]", pe_ready[CORES-1:1], 0);
    if (DUT.wr_bus.mem_we !== 1'b0)
      report_mismatch("mem_we", DUT.wr_bus.mem_we, 0);
    if (DUT.s2m_we !== 1'b0)
      report_mismatch("s2m_we", DUT.s2m_we, 0);
    finish_test("reset state", start_errors);
  endtask

  task automatic data_memory_test();
    int start_errors;
    start_errors = errors;
    for (int i = 0; i < 8; i++)
    begin
      burst_exp[i] = random_bits(32);
      burst_addr[i] = rd_address(soc_fabric_pkg::R_BANK_MEM_D, 11'(i * 5 + 3));
      issue_write(wr_address(soc_fabric_pkg::W_BANK_MEM_D, 11'(i * 5 + 3)), burst_exp[i]);
    end
    run_read_burst(8, "m_r_data from data memory");
    finish_test("data memory", start_errors);
  endtask

  task automatic control_reg_test();
    int start_errors;
    logic [31:0] data;
    start_errors = errors;
    data = random_bits(32);
    issue_write(wr_address(soc_fabric_pkg::W_BANK_IO_REG, 11'(soc_fabric_pkg::IO_W_LED)), data);
    if (led !== 16'h0)
      report_mismatch("led one cycle after write", led, 0);
    @(negedge clk);
    if (led !== data[15:0])
      report_mismatch("led", led, data[15:0]);
    data = random_bits(32);
    data[0] = 1'b1;
    issue_write(wr_address(soc_fabric_pkg::W_BANK_IO_REG,
                           11'(soc_fabric_pkg::IO_W_RESET_PE)), data);
    if (pe_soft_reset !== 1'b0)
      report_mismatch("pe_soft_reset one cycle after write", pe_soft_reset, 0);
    @(negedge clk);
    if (pe_soft_reset !== 1'b1)
      report_mismatch("pe_soft_reset", pe_soft_reset, 1);
    // Unmapped status index
    burst_addr[0] = rd_address(soc_fabric_pkg::R_BANK_IO_REG, 11'd5);
    burst_exp[0] = '0;
    run_read_burst(1, "m_r_data from I/O index 5");
    finish_test("control registers", start_errors);
  endtask

  task automatic uart_test();
    int start_errors;
    logic [31:0] data;
    start_errors = errors;
    data = random_bits(32);
    issue_write(wr_address(soc_fabric_pkg::W_BANK_IO_REG, 11'(soc_fabric_pkg::IO_W_UART)), data);
    if (tx_valid !== 1'b0)
      report_mismatch("tx_valid one cycle after write", tx_valid, 0);
    repeat (3)
    begin
      @(negedge clk);
      if (tx_valid !== 1'b1)
        report_mismatch("tx_valid", tx_valid, 1);
      if (tx_data !== data[7:0])
        report_mismatch("tx_data", tx_data, data[7:0]);
    end
    // Index 5 stays zero even while busy is set
    burst_addr[0] = rd_address(soc_fabric_pkg::R_BANK_IO_REG,
                               11'(soc_fabric_pkg::IO_R_UART_BUSY));
    burst_exp[0] = 32'd1;
    burst_addr[1] = rd_address(soc_fabric_pkg::R_BANK_IO_REG, 11'd5);
    burst_exp[1] = 32'd0;
    run_read_burst(2, "m_r_data status while pending");
    @(negedge clk);
    tx_ready = 1'b1;
    @(negedge clk);
    tx_ready = 1'b0;
    if (tx_valid !== 1'b0)
      report_mismatch("tx_valid after handshake", tx_valid, 0);
    burst_exp[0] = 32'd0;
    run_read_burst(1, "m_r_data busy after handshake");
    finish_test("UART handoff", start_errors);
  endtask

  task automatic broadcast_test();
    int start_errors;
    logic [31:0] data;
    logic [W_ADDR_W-1:0] addr;
    logic exp_valid;
    start_errors = errors;
    for (int b = 0; b < 8; b++)
    begin
      data = random_bits(32);
      addr = wr_address(3'(b), 11'h13C);
      exp_valid = (b >= 2);
      issue_write(addr, data);
      if (pe_w_valid !== exp_valid)
        report_mismatch("pe_w_valid", pe_w_valid, exp_valid);
      if (exp_valid && pe_w_addr !== addr)
        report_mismatch("pe_w_addr", pe_w_addr, addr);
      if (exp_valid && pe_w_data !== data)
        report_mismatch("pe_w_data", pe_w_data, data);
      @(negedge clk);
      if (pe_w_valid !== 1'b0)
        report_mismatch("pe_w_valid second cycle", pe_w_valid, 0);
    end
    finish_test("PE broadcast", start_errors);
  endtask

  task automatic harvest_test();
    int start_errors;
    int item [CORES];
    logic [31:0] res_data [CORES][3];
    logic [CORES-1:0] hs;
    int done_lanes;
    int guard;
    start_errors = errors;
    hs = '0;
    done_lanes = 0;
    guard = 0;
    for (int l = 0; l < CORES; l++)
    begin
      item[l] = 0;
      for (int j = 0; j < 3; j++)
        res_data[l][j] = random_bits(32);
    end
    while (done_lanes < CORES && guard < 100)
    begin
      @(negedge clk);
      guard++;
      done_lanes = 0;
      // Lanes that handed off at the last edge move to their next item
      for (int l = 0; l < CORES; l++)
      begin
        if (hs[l])
          item[l]++;
        if (item[l] < 3)
        begin
          pe_valid[l] = 1'b1;
          pe_res_addr[l*S2M_AW +: S2M_AW] = harvest_addr(l, item[l]);
          pe_res_data[l*DATA_W +: DATA_W] = res_data[l][item[l]];
        end
        else
        begin
          pe_valid[l] = 1'b0;
          done_lanes++;
        end
      end
      if ($countones(pe_ready) > 1)
        report_failure("more than one PE lane ready in the same cycle");
      hs = pe_valid & pe_ready;
    end
    if (done_lanes < CORES)
      report_failure("harvester did not accept every PE result");
    @(negedge clk);
    for (int l = 0; l < CORES; l++)
    begin
      for (int j = 0; j < 3; j++)
      begin
        burst_addr[l*3 + j] = rd_address(soc_fabric_pkg::R_BANK_S2M, 11'(harvest_addr(l, j)));
        burst_exp[l*3 + j] = res_data[l][j];
      end
    end
    run_read_burst(CORES * 3, "m_r_data from result memory");
    finish_test("harvest", start_errors);
  endtask

  initial
  begin
    rst_n = 1'b0;
    m_w_valid = 1'b0;
    m_w_addr = '0;
    m_w_data = '0;
    m_r_valid = 1'b0;
    m_r_addr = '0;
    pe_valid = '0;
    pe_res_addr = '0;
    pe_res_data = '0;
    tx_ready = 1'b0;
    lfsr_state = 32'h7791;
    repeat (5) @(negedge clk);
    reset_test();
    rst_n = 1'b1;
    data_memory_test();
    control_reg_test();
    uart_test();
    broadcast_test();
    harvest_test();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* files.f */
soc_fabric_pkg.sv
master_wr_if.sv
shared_ram.sv
master_write_decode.sv
io_reg_file.sv
result_harvester.sv
master_read_mux.sv
soc_fabric.sv
tb_soc_fabric.sv
